/* common/sv32_pkg.sv */
package sv32_pkg;

    typedef logic [31:0] vaddr_t;
    typedef logic [31:0] paddr_t;
    typedef logic [31:0] pte_t;
    typedef logic [9:0]  vpn_t;
    typedef logic [1:0]  priv_t;

    localparam priv_t PRIV_USER    = 2'b00;
    localparam priv_t PRIV_SUPER   = 2'b01;
    localparam priv_t PRIV_MACHINE = 2'b11;

    // pte flag bits
    localparam int PTE_V = 0;
    localparam int PTE_R = 1;
    localparam int PTE_W = 2;
    localparam int PTE_X = 3;
    localparam int PTE_U = 4;
    localparam int PTE_A = 6;
    localparam int PTE_D = 7;

    typedef enum logic [2:0] {
        IDLE     = 3'd0,
        FETCH_L1 = 3'd1,
        CHECK_L1 = 3'd2,
        FETCH_L0 = 3'd3,
        CHECK_L0 = 3'd4,
        DONE     = 3'd5
    } walk_state_t;

endpackage

/* common/pte_walk_if.sv */
`timescale 1ns/1ps

interface pte_walk_if;

    logic              capture; // latch memory data this edge
    logic              level;   // 1 = level 1, 0 = level 0
    sv32_pkg::pte_t    pte;
    logic              leaf;
    logic              fault;
    sv32_pkg::paddr_t  pa;

    modport fsm (
        output capture,
        output level,
        input  leaf,
        input  fault,
        input  pa
    );

    modport fetch (
        input  capture,
        input  level,
        output pte
    );

    modport check (
        input  level,
        input  pte,
        output leaf,
        output fault,
        output pa
    );

endinterface

/* design/walk_timer.sv */
`timescale 1ns/1ps

module walk_timer #(
    parameter int TIMEOUT_CYCLES = 64
) (
    input  logic clk,
    input  logic rst,
    input  logic run,
    output logic expired
);

    localparam int CW = $clog2(TIMEOUT_CYCLES + 1);

    logic [CW-1:0] count;

    always_ff @(posedge clk) begin
        if (rst || !run) begin
            count <= '0;
        end else if (count != CW'(TIMEOUT_CYCLES)) begin
            count <= count + 1'b1; // saturates at the limit
        end
    end

    assign expired = (count == CW'(TIMEOUT_CYCLES));

endmodule

/* mmu/pte_check.sv */
`timescale 1ns/1ps

module pte_check (
    input  sv32_pkg::vaddr_t  va,
    input  sv32_pkg::priv_t   priv,
    input  logic              sum,
    input  logic              access_is_inst,
    input  logic              access_is_load,
    input  logic              access_is_store,
    pte_walk_if.check         walk
);

    logic v, r, w, x, u, a, d;
    logic is_leaf;
    logic bad_pte;
    logic priv_fault;
    logic ptr_fault;
    logic misaligned;
    logic perm_fault;

    assign v = walk.pte[sv32_pkg::PTE_V];
    assign r = walk.pte[sv32_pkg::PTE_R];
    assign w = walk.pte[sv32_pkg::PTE_W];
    assign x = walk.pte[sv32_pkg::PTE_X];
    assign u = walk.pte[sv32_pkg::PTE_U];
    assign a = walk.pte[sv32_pkg::PTE_A];
    assign d = walk.pte[sv32_pkg::PTE_D];

    assign is_leaf = r || x;
    assign bad_pte = !v || (w && !r);

    // U only means something on a leaf
    assign priv_fault = is_leaf &&
                        (((priv == sv32_pkg::PRIV_USER) && !u) ||
                         ((priv == sv32_pkg::PRIV_SUPER) && u && (!sum || access_is_inst)));

    assign ptr_fault  = !is_leaf && !walk.level;            // pointer at level 0
    assign misaligned = is_leaf && walk.level && (walk.pte[19:10] != '0);

    // no hardware A/D update, so a clear A or a store with D clear traps
    assign perm_fault = is_leaf &&
                        (!a ||
                         (access_is_inst  && !x) ||
                         (access_is_load  && !r) ||
                         (access_is_store && (!w || !d)));

    always_comb begin
        walk.fault = 1'b0;
        walk.leaf  = 1'b0;
        if (bad_pte) begin
            walk.fault = 1'b1;
        end else if (priv_fault) begin
            walk.fault = 1'b1;
        end else if (ptr_fault) begin
            walk.fault = 1'b1;
        end else if (misaligned) begin
            walk.fault = 1'b1;
        end else if (perm_fault) begin
            walk.fault = 1'b1;
        end else begin
            walk.leaf = is_leaf;
        end
    end

    // 32-bit physical space, ppn bits 31:30 dropped
    assign walk.pa = walk.level ? {walk.pte[29:20], va[21:0]}
                                : {walk.pte[29:10], va[11:0]};

endmodule

/* mmu/pte_fetch_regs.sv */
`timescale 1ns/1ps

module pte_fetch_regs (
    input  logic              clk,
    input  logic              rst,
    input  logic [21:0]       satp_ppn,
    input  sv32_pkg::vaddr_t  va,
    input  logic [7:0]        mem_b0,
    input  logic [7:0]        mem_b1,
    input  logic [7:0]        mem_b2,
    input  logic [7:0]        mem_b3,
    pte_walk_if.fetch         walk,
    output sv32_pkg::paddr_t  mem_addr
);

    sv32_pkg::vpn_t  vpn1;
    sv32_pkg::vpn_t  vpn0;
    sv32_pkg::pte_t  l1_pte;
    sv32_pkg::pte_t  l0_pte;
    sv32_pkg::pte_t  mem_word;
    logic [33:0]     l1_addr;
    logic [33:0]     l0_addr;

    assign vpn1 = va[31:22];
    assign vpn0 = va[21:12];

    // table base + 4 * vpn, upper two bits fall off
    assign l1_addr = {satp_ppn, 12'b0} + 34'({vpn1, 2'b00});
    assign l0_addr = {l1_pte[31:10], 12'b0} + 34'({vpn0, 2'b00});

    assign mem_addr = walk.level ? l1_addr[31:0] : l0_addr[31:0];

    assign mem_word = {mem_b3, mem_b2, mem_b1, mem_b0}; // b0 is the low byte

    always_ff @(posedge clk) begin
        if (rst) begin
            l1_pte <= '0;
            l0_pte <= '0;
        end else if (walk.capture) begin
            if (walk.level) begin
                l1_pte <= mem_word;
            end else begin
                l0_pte <= mem_word;
            end
        end
    end

    assign walk.pte = walk.level ? l1_pte : l0_pte;

endmodule

/* mmu/mmu_walk_fsm.sv */
`timescale 1ns/1ps

module mmu_walk_fsm (
    input  logic              clk,
    input  logic              rst,
    input  sv32_pkg::vaddr_t  va,
    input  logic              satp_mode,
    input  sv32_pkg::priv_t   priv,
    input  logic              access_is_inst,
    input  logic              access_is_load,
    input  logic              access_is_store,
    input  logic              mem_resolved,
    input  logic              hold,
    input  logic              expired,
    pte_walk_if.fsm           walk,
    output logic              stall,
    output logic              mem_req,
    output sv32_pkg::paddr_t  pa,
    output logic              instr_fault,
    output logic              load_fault,
    output logic              store_fault
);

    sv32_pkg::walk_state_t state;
    logic                  fault_q;
    logic                  waiting;
    logic                  checking;
    logic                  check_done;
    logic                  walk_start;

    assign waiting    = (state == sv32_pkg::FETCH_L1) || (state == sv32_pkg::FETCH_L0);
    assign checking   = (state == sv32_pkg::CHECK_L1) || (state == sv32_pkg::CHECK_L0);
    assign check_done = checking && (walk.fault || walk.leaf);
    assign walk_start = satp_mode && (priv != sv32_pkg::PRIV_MACHINE);

    assign walk.capture = waiting && mem_resolved;
    assign walk.level   = !((state == sv32_pkg::FETCH_L0) || (state == sv32_pkg::CHECK_L0));

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= sv32_pkg::IDLE;
            stall   <= 1'b0;
            mem_req <= 1'b0;
            fault_q <= 1'b0;
        end else begin
            case (state)
                sv32_pkg::IDLE: begin
                    if (walk_start) begin
                        stall   <= 1'b1;
                        mem_req <= 1'b1; // level-1 read
                        fault_q <= 1'b0;
                        state   <= sv32_pkg::FETCH_L1;
                    end
                end
                sv32_pkg::FETCH_L1,
                sv32_pkg::FETCH_L0: begin
                    if (mem_resolved) begin
                        mem_req <= 1'b0;
                        state   <= (state == sv32_pkg::FETCH_L1) ? sv32_pkg::CHECK_L1
                                                                 : sv32_pkg::CHECK_L0;
                    end else if (expired) begin
                        // no answer from memory, give up
                        mem_req <= 1'b0;
                        fault_q <= 1'b1;
                        state   <= sv32_pkg::DONE;
                    end
                end
                sv32_pkg::CHECK_L1,
                sv32_pkg::CHECK_L0: begin
                    if (check_done) begin
                        fault_q <= walk.fault;
                        state   <= sv32_pkg::DONE;
                    end else begin
                        mem_req <= 1'b1; // pointer, go down a level
                        state   <= sv32_pkg::FETCH_L0;
                    end
                end
                sv32_pkg::DONE: begin
                    stall <= 1'b0;
                    if (!hold) begin
                        state <= sv32_pkg::IDLE;
                    end
                end
                default: begin
                    state <= sv32_pkg::IDLE;
                end
            endcase
        end
    end

    // result register, loaded on the way into DONE
    always_ff @(posedge clk) begin
        if (check_done) begin
            pa <= walk.fault ? va : walk.pa;
        end else if (waiting && !mem_resolved && expired) begin
            pa <= va;
        end
    end

    // only the strobe for the current access type fires
    assign instr_fault = (state == sv32_pkg::DONE) && fault_q && access_is_inst;
    assign load_fault  = (state == sv32_pkg::DONE) && fault_q && access_is_load;
    assign store_fault = (state == sv32_pkg::DONE) && fault_q && access_is_store;

endmodule

/* design/mmu_top.sv */
`timescale 1ns/1ps

module mmu_top #(
    parameter int TIMEOUT_CYCLES = 64
) (
    input  logic              clk,
    input  logic              rst,
    input  sv32_pkg::vaddr_t  va,
    input  logic [31:0]       satp,
    input  sv32_pkg::priv_t   priv,
    input  logic              sum,
    input  logic              access_is_inst,
    input  logic              access_is_load,
    input  logic              access_is_store,
    input  logic              mem_resolved,
    input  logic [7:0]        mem_b0,
    input  logic [7:0]        mem_b1,
    input  logic [7:0]        mem_b2,
    input  logic [7:0]        mem_b3,
    input  logic              hold,
    output logic              stall,
    output logic              mem_req,
    output sv32_pkg::paddr_t  mem_addr,
    output sv32_pkg::paddr_t  pa,
    output logic              instr_fault,
    output logic              load_fault,
    output logic              store_fault,
    output sv32_pkg::vaddr_t  faulting_va
);

    pte_walk_if walk_bus ();

    logic expired;

    assign faulting_va = va;

    mmu_walk_fsm u_fsm (
        .clk             (clk),
        .rst             (rst),
        .va              (va),
        .satp_mode       (satp[31]),
        .priv            (priv),
        .access_is_inst  (access_is_inst),
        .access_is_load  (access_is_load),
        .access_is_store (access_is_store),
        .mem_resolved    (mem_resolved),
        .hold            (hold),
        .expired         (expired),
        .walk            (walk_bus.fsm),
        .stall           (stall),
        .mem_req         (mem_req),
        .pa              (pa),
        .instr_fault     (instr_fault),
        .load_fault      (load_fault),
        .store_fault     (store_fault)
    );

    pte_fetch_regs u_fetch (
        .clk      (clk),
        .rst      (rst),
        .satp_ppn (satp[21:0]),
        .va       (va),
        .mem_b0   (mem_b0),
        .mem_b1   (mem_b1),
        .mem_b2   (mem_b2),
        .mem_b3   (mem_b3),
        .walk     (walk_bus.fetch),
        .mem_addr (mem_addr)
    );

    pte_check u_check (
        .va              (va),
        .priv            (priv),
        .sum             (sum),
        .access_is_inst  (access_is_inst),
        .access_is_load  (access_is_load),
        .access_is_store (access_is_store),
        .walk            (walk_bus.check)
    );

    // mem_req is already registered in the FSM
    walk_timer #(
        .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
    ) u_timer (
        .clk     (clk),
        .rst     (rst),
        .run     (mem_req),
        .expired (expired)
    );

endmodule

/* testbench/pt_mem_model.sv */
`timescale 1ns/1ps

module pt_mem_model (
    input  logic        clk,
    input  logic        rst,
    input  logic        mem_req,
    input  logic [31:0] mem_addr,
    input  logic        mute,
    output logic        mem_resolved,
    output logic [7:0]  mem_b0,
    output logic [7:0]  mem_b1,
    output logic [7:0]  mem_b2,
    output logic [7:0]  mem_b3
);

    logic [31:0] words [logic [31:0]]; // keyed by byte address
    logic [31:0] rand_state = 32'h356de7ae;

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rand_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rand_state = x;
        return x;
    endfunction

    initial begin
        logic        busy;
        int          wait_cnt;
        logic [31:0] req_addr;
        logic [31:0] word;
        busy = 1'b0;
        wait_cnt = 0;
        req_addr = '0;
        mem_resolved = 1'b0;
        {mem_b3, mem_b2, mem_b1, mem_b0} = '0;
        forever begin
            @(posedge clk);
            #1;
            mem_resolved = 1'b0;
            if (rst) begin
                busy = 1'b0;
            end else begin
                if (!busy && mem_req && !mute) begin
                    busy = 1'b1;
                    req_addr = mem_addr;
                    wait_cnt = int'(next_rand() % 8); // 0 to 7 cycles
                end
                if (busy) begin
                    if (wait_cnt == 0) begin
                        word = words.exists(req_addr) ? words[req_addr] : '0;
                        {mem_b3, mem_b2, mem_b1, mem_b0} = word;
                        mem_resolved = 1'b1;
                        busy = 1'b0;
                    end else begin
                        wait_cnt--;
                    end
                end
            end
        end
    end

endmodule

/* testbench/mmu_tb.sv */
`timescale 1ns/1ps

module mmu_tb;

    localparam int TIMEOUT_CYCLES = 64;
    localparam int NUM_CASES = 29;
    localparam int CASE_LIMIT = 2 * TIMEOUT_CYCLES + 40;
    localparam logic [21:0] ROOT_PPN = 22'h00010;
    localparam logic [31:0] L0_BASE = 32'h0002_0000;
    localparam sv32_pkg::pte_t PTR = 32'h0000_8001; // points at L0_BASE
    localparam sv32_pkg::vaddr_t VA = 32'h1234_5678;

    logic clk, rst, sum, hold, mute;
    logic access_is_inst, access_is_load, access_is_store;
    logic mem_resolved, stall, mem_req;
    logic instr_fault, load_fault, store_fault;
    logic [7:0] mem_b0, mem_b1, mem_b2, mem_b3;
    logic [31:0] satp;
    sv32_pkg::vaddr_t va, faulting_va;
    sv32_pkg::priv_t priv;
    sv32_pkg::paddr_t mem_addr, pa;

    logic [31:0] rand_state = 32'h356de7ae;
    string exp_name;
    int exp_kind;
    logic exp_fault;
    sv32_pkg::paddr_t exp_pa, held_pa;
    logic [2:0] held_strobes;
    int case_no = 0;
    int checked_no = 0;

    mmu_top #(.TIMEOUT_CYCLES(TIMEOUT_CYCLES)) UUT (
        .clk(clk), .rst(rst), .va(va), .satp(satp), .priv(priv), .sum(sum),
        .access_is_inst(access_is_inst), .access_is_load(access_is_load),
        .access_is_store(access_is_store), .mem_resolved(mem_resolved),
        .mem_b0(mem_b0), .mem_b1(mem_b1), .mem_b2(mem_b2), .mem_b3(mem_b3),
        .hold(hold), .stall(stall), .mem_req(mem_req), .mem_addr(mem_addr), .pa(pa),
        .instr_fault(instr_fault), .load_fault(load_fault), .store_fault(store_fault),
        .faulting_va(faulting_va)
    );

    pt_mem_model u_mem (
        .clk(clk), .rst(rst), .mem_req(mem_req), .mem_addr(mem_addr), .mute(mute),
        .mem_resolved(mem_resolved),
        .mem_b0(mem_b0), .mem_b1(mem_b1), .mem_b2(mem_b2), .mem_b3(mem_b3)
    );

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rand_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rand_state = x;
        return x;
    endfunction

    function automatic sv32_pkg::pte_t leaf_pte(input logic [19:0] ppn, input logic [7:0] flags);
        return {2'b00, ppn, 2'b00, flags};
    endfunction

    function automatic logic [31:0] read_word(input logic [31:0] addr);
        return u_mem.words.exists(addr) ? u_mem.words[addr] : 32'h0;
    endfunction

    // result is {fault, pa} and kind is 0 fetch, 1 load or 2 store
    function automatic logic [32:0] ref_translate(input sv32_pkg::vaddr_t v,
            input logic [21:0] root, input sv32_pkg::priv_t p, input logic s, input int kind);
        logic [31:0] base;
        sv32_pkg::pte_t e;
        logic bad;
        base = {root[19:0], 12'h000};
        for (int lvl = 1; lvl >= 0; lvl--) begin
            e = read_word(base + ((lvl == 1) ? 32'(v[31:22]) << 2 : 32'(v[21:12]) << 2));
            if (!e[sv32_pkg::PTE_V] || (e[sv32_pkg::PTE_W] && !e[sv32_pkg::PTE_R]))
                return {1'b1, v};
            if (e[sv32_pkg::PTE_R] || e[sv32_pkg::PTE_X]) begin
                bad = (p == sv32_pkg::PRIV_USER && !e[sv32_pkg::PTE_U]) ||
                      (p == sv32_pkg::PRIV_SUPER && e[sv32_pkg::PTE_U] && (!s || kind == 0)) ||
                      (lvl == 1 && e[19:10] != 10'h0) || !e[sv32_pkg::PTE_A] ||
                      (kind == 0 && !e[sv32_pkg::PTE_X]) || (kind == 1 && !e[sv32_pkg::PTE_R]) ||
                      (kind == 2 && !(e[sv32_pkg::PTE_W] && e[sv32_pkg::PTE_D]));
                if (bad)
                    return {1'b1, v};
                return (lvl == 1) ? {1'b0, e[29:20], v[21:0]} : {1'b0, e[29:10], v[11:0]};
            end
            base = {e[29:10], 12'h000};
        end
        return {1'b1, v}; // pointer at level 0
    endfunction

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // the first DONE cycle carries the result and later ones hold it
    always @(negedge clk) begin
        if (!rst && UUT.u_fsm.state == sv32_pkg::DONE) begin
            if (checked_no != case_no) begin
                assert ({instr_fault, load_fault, store_fault} ==
                        (exp_fault ? 3'b100 >> exp_kind : 3'b000))
                else fail_now($sformatf("error %s: strobes expected %b actual %b", exp_name,
                              exp_fault ? 3'b100 >> exp_kind : 3'b000,
                              {instr_fault, load_fault, store_fault}));
                if (!exp_fault) begin
                    assert (pa == exp_pa)
                    else fail_now($sformatf("error %s: pa expected %h actual %h",
                                  exp_name, exp_pa, pa));
                end
                assert (faulting_va == va)
                else fail_now($sformatf("error %s: faulting_va expected %h actual %h",
                              exp_name, va, faulting_va));
                assert (stall)
                else fail_now($sformatf("error %s: stall expected 1 actual %b",
                              exp_name, stall));
                held_pa = pa;
                held_strobes = {instr_fault, load_fault, store_fault};
                checked_no = case_no;
            end else begin
                assert (pa == held_pa && {instr_fault, load_fault, store_fault} == held_strobes)
                else fail_now($sformatf("error %s: held result expected %h %b actual %h %b",
                              exp_name, held_pa, held_strobes, pa,
                              {instr_fault, load_fault, store_fault}));
                assert (!stall)
                else fail_now($sformatf("error %s: stall expected 0 actual %b",
                              exp_name, stall));
            end
        end
    end

    task automatic run_case(input string name, input sv32_pkg::vaddr_t v,
            input sv32_pkg::priv_t p, input logic s, input int kind,
            input sv32_pkg::pte_t l1, input sv32_pkg::pte_t l0,
            input int hold_for, input logic muted);
        logic [32:0] want;
        int waited;
        u_mem.words.delete();
        u_mem.words[{ROOT_PPN[19:0], 12'h000} + (32'(v[31:22]) << 2)] = l1;
        u_mem.words[L0_BASE + (32'(v[21:12]) << 2)] = l0;
        want = ref_translate(v, ROOT_PPN, p, s, kind);
        @(posedge clk);
        #1;
        va = v;
        satp = {1'b1, 9'h0, ROOT_PPN};
        priv = p;
        sum = s;
        {access_is_inst, access_is_load, access_is_store} = 3'b100 >> kind;
        hold = (hold_for > 0);
        mute = muted;
        exp_name = name;
        exp_kind = kind;
        exp_fault = want[32] || muted;
        exp_pa = want[31:0];
        case_no++;
        waited = 0;
        while (checked_no != case_no && waited < CASE_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        assert (checked_no == case_no) else fail_now($sformatf("%s: walk never finished", name));
        repeat (hold_for) @(posedge clk);
        #1;
        if (hold_for > 0) begin
            assert (UUT.u_fsm.state == sv32_pkg::DONE)
            else fail_now($sformatf("%s: walker left DONE while hold was high", name));
        end
        hold = 1'b0;
        satp[31] = 1'b0;
        mute = 1'b0;
        repeat (3) @(posedge clk);
    endtask

    task automatic idle_case(input string name, input logic mode, input sv32_pkg::priv_t p);
        @(posedge clk);
        #1;
        satp = {mode, 9'h0, ROOT_PPN};
        priv = p;
        repeat (20) begin
            @(negedge clk);
            assert (!stall && !mem_req)
            else fail_now($sformatf("%s: walker started with translation off", name));
        end
        @(posedge clk);
        #1;
        satp[31] = 1'b0;
    endtask

    initial begin
        logic [31:0] r;
        {rst, sum, hold, mute, access_is_inst, access_is_load, access_is_store} = 7'b1000000;
        satp = '0;
        va = '0;
        priv = sv32_pkg::PRIV_SUPER;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int i = 0; i < 12; i++) begin
            r = next_rand();
            run_case($sformatf("l0_leaf_%0d", i), next_rand(), sv32_pkg::PRIV_SUPER, 1'b0,
                     i % 3, PTR, leaf_pte(r[19:0], 8'hCF),
                     (i % 2 == 1) ? int'(next_rand() % 12) + 1 : 0, 1'b0);
        end
        run_case("superpage", VA, sv32_pkg::PRIV_SUPER, 1'b0, 1,
                 leaf_pte({10'h155, 10'h000}, 8'hCF), 32'h0, 0, 1'b0);
        run_case("misaligned_superpage", VA, sv32_pkg::PRIV_SUPER, 1'b0, 0,
                 leaf_pte({10'h155, 10'h001}, 8'hCF), 32'h0, 0, 1'b0);
        run_case("user_no_u", VA, sv32_pkg::PRIV_USER, 1'b0, 1, PTR,
                 leaf_pte(20'h45a5a, 8'hCF), 0, 1'b0);
        run_case("user_u", VA, sv32_pkg::PRIV_USER, 1'b0, 2, PTR,
                 leaf_pte(20'h45a5a, 8'hDF), 0, 1'b0);
        run_case("super_u_sum0", VA, sv32_pkg::PRIV_SUPER, 1'b0, 1, PTR,
                 leaf_pte(20'h45a5a, 8'hDF), 0, 1'b0);
        run_case("super_u_sum1", VA, sv32_pkg::PRIV_SUPER, 1'b1, 1, PTR,
                 leaf_pte(20'h45a5a, 8'hDF), 0, 1'b0);
        run_case("super_u_fetch", VA, sv32_pkg::PRIV_SUPER, 1'b1, 0, PTR,
                 leaf_pte(20'h45a5a, 8'hDF), 0, 1'b0);
        run_case("no_x", VA, sv32_pkg::PRIV_SUPER, 1'b0, 0, PTR,
                 leaf_pte(20'h45a5a, 8'hC7), 0, 1'b0);
        run_case("no_r", VA, sv32_pkg::PRIV_SUPER, 1'b0, 1, PTR,
                 leaf_pte(20'h45a5a, 8'hC9), 0, 1'b0);
        run_case("no_w", VA, sv32_pkg::PRIV_SUPER, 1'b0, 2, PTR,
                 leaf_pte(20'h45a5a, 8'hCB), 0, 1'b0);
        run_case("store_d_clear", VA, sv32_pkg::PRIV_SUPER, 1'b0, 2, PTR,
                 leaf_pte(20'h45a5a, 8'h4F), 0, 1'b0);
        run_case("v_clear", VA, sv32_pkg::PRIV_SUPER, 1'b0, 1, 32'h0, 32'h0, 0, 1'b0);
        run_case("w_without_r", VA, sv32_pkg::PRIV_SUPER, 1'b0, 2,
                 leaf_pte(20'h45a5a, 8'hC5), 32'h0, 0, 1'b0);
        run_case("pointer_at_l0", VA, sv32_pkg::PRIV_SUPER, 1'b0, 0, PTR, PTR, 0, 1'b0);
        run_case("read_timeout", VA, sv32_pkg::PRIV_SUPER, 1'b0, 1, PTR,
                 leaf_pte(20'h45a5a, 8'hCF), int'(next_rand() % 12) + 1, 1'b1);
        idle_case("satp_off", 1'b0, sv32_pkg::PRIV_SUPER);
        idle_case("machine_mode", 1'b1, sv32_pkg::PRIV_MACHINE);
        $display("TEST RESULT: PASS");
        $finish;
    end

    initial begin
        repeat (NUM_CASES * CASE_LIMIT) @(posedge clk);
        fail_now("watchdog expired before all cases finished");
    end

endmodule

/* sv32_mmu.f */
common/sv32_pkg.sv
common/pte_walk_if.sv
design/walk_timer.sv
mmu/pte_check.sv
mmu/pte_fetch_regs.sv
mmu/mmu_walk_fsm.sv
design/mmu_top.sv
testbench/pt_mem_model.sv
testbench/mmu_tb.sv

/* Bender.yml */
package:
  name: sv32_mmu

sources:
  - common/sv32_pkg.sv
  - common/pte_walk_if.sv
  - design/walk_timer.sv
  - mmu/pte_check.sv
  - mmu/pte_fetch_regs.sv
  - mmu/mmu_walk_fsm.sv
  - design/mmu_top.sv
  - target: test
    files:
      - testbench/pt_mem_model.sv
      - testbench/mmu_tb.sv
